// ==== bench/fetchGolden.txt ====
# op arg0 arg1 arg2 arg3 expPc expWord0 expValid expHit expTaken expTarget, all hex
# refill addr word0, train pc target type taken, redirectEx exTgt idValid idTgt stall
step 0 0 0 0 1000 0 0 0 0 0
refill 1010 11000000 0 0 1000 0 0 0 0 0
refill 1020 12000000 0 0 1000 0 0 0 0 0
refill 1030 13000000 0 0 1000 0 0 0 0 0
refill 1000 10000000 0 0 1000 10000000 1 0 0 0
step 0 0 0 0 1010 11000000 1 0 0 0
step 0 0 0 0 1020 12000000 1 0 0 0
stall 0 0 0 0 1020 12000000 1 0 0 0
redirectEx 1000 0 0 1 1000 10000000 1 0 0 0
redirectEx 1030 1 1010 0 1030 13000000 1 0 0 0
redirectId 1010 0 0 0 1010 11000000 1 0 0 0
train 1008 1030 2 1 1020 12000000 1 0 0 0
redirectId 1000 0 0 0 1000 10000000 1 4 4 1030
step 0 0 0 0 1030 13000000 1 0 0 0
redirectId 1010 0 0 0 1010 11000000 1 0 0 0
step 0 0 0 0 1020 12000000 1 0 0 0
train 1014 1000 3 1 1030 13000000 1 0 0 0
train 1014 1000 3 1 1040 0 0 0 0 0
train 1028 1000 3 1 1040 0 0 0 0 0
redirectEx 1010 0 0 0 1010 11000000 1 2 2 1000
step 0 0 0 0 1000 10000000 1 4 4 1030
step 0 0 0 0 1030 13000000 1 0 0 0
redirectId 1020 0 0 0 1020 12000000 1 4 4 1000
step 0 0 0 0 1000 10000000 1 4 4 1030
train 1034 1020 1 1 1030 13000000 1 2 2 1020
train 1024 0 0 1 1020 12000000 1 6 2 1038
step 0 0 0 0 1038 13000000 1 0 0 0

// ==== src.f ====
common/fetchPkg.sv
source/branchTargetBuffer.sv
source/directionPredictor.sv
source/returnAddrStack.sv
icache/instCache.sv
fetch/fetchStage1.sv
source/fetchTop.sv
bench/fetchTb.sv

// ==== Bender.yml ====
package:
  name: fetchStage

sources:
  - common/fetchPkg.sv
  - source/branchTargetBuffer.sv
  - source/directionPredictor.sv
  - source/returnAddrStack.sv
  - icache/instCache.sv
  - fetch/fetchStage1.sv
  - source/fetchTop.sv
  - target: test
    files:
      - bench/fetchTb.sv

// ==== bench/fetchTb.sv ====
`timescale 1ns/10ps

module fetchTb;

	localparam int pollLimit = 20;	// Cycles allowed for a refilled line to appear.

	logic                         clk;
	logic                         reset;
	logic                         stall;
	fetchPkg::redirectT           redirect;
	fetchPkg::trainT              trainRec;
	fetchPkg::refillT             refill;
	fetchPkg::fetchBundleT        bundle;
	logic                         bundleValid;
	logic                         miss;
	logic [fetchPkg::pcWidth-1:0] missAddr;

	int                    fd;
	int                    nRead;
	int                    errorCount;
	int                    checkCount;
	int                    opCount;
	logic [8*16-1:0]       opWord;			// Opcode token of the current line.
	logic [8*256-1:0]      restOfLine;
	logic [31:0]           args [4];		// Operands whose meaning depends on the opcode.
	logic [31:0]           expPc;
	logic [31:0]           expWord;			// Expected slot 0 word.
	logic [31:0]           expValid;
	logic [31:0]           expHit;			// One bit per slot.
	logic [31:0]           expTaken;		// Only the first taken slot.
	logic [31:0]           expTarget;		// Target of the taken slot.
	fetchPkg::fetchBundleT expBundle;
	logic [31:0]           trainedPc [$];	// Branch addresses written into the BTB.
	fetchPkg::brTypeE      trainedType [$];	// Their trained classes.

	fetchTop DUT (
		.clk(clk),
		.reset(reset),
		.stall_i(stall),
		.redirect_i(redirect),
		.train_i(trainRec),
		.refill_i(refill),
		.bundle_o(bundle),
		.bundleValid_o(bundleValid),
		.miss_o(miss),
		.missAddr_o(missAddr)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period.
	end

	task automatic comparePc(input string name, input logic [fetchPkg::pcWidth-1:0] expected,
		input logic [fetchPkg::pcWidth-1:0] actual);
	begin
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	end
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
	begin
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	end
	endtask

	task automatic compareType(input string name, input fetchPkg::brTypeE expected,
		input fetchPkg::brTypeE actual);
	begin
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	end
	endtask

	task automatic compareBundle(input fetchPkg::fetchBundleT expected,
		input fetchPkg::fetchBundleT actual, input logic wordsKnown);
	begin
		comparePc("bundle_o.pc", expected.pc, actual.pc);
		for (int s = 0; s < fetchPkg::fetchSlots; s++)
		begin
			if (wordsKnown)
			begin
				comparePc($sformatf("bundle_o.inst[%0d]", s), expected.inst[s], actual.inst[s]);
			end
			compareFlag($sformatf("bundle_o.pred[%0d].hit", s),
				expected.pred[s].hit, actual.pred[s].hit);
			if (expected.pred[s].hit)
			begin
				compareType($sformatf("bundle_o.pred[%0d].brType", s),
					expected.pred[s].brType, actual.pred[s].brType);
			end
			compareFlag($sformatf("bundle_o.pred[%0d].taken", s),
				expected.pred[s].taken, actual.pred[s].taken);
			if (expected.pred[s].taken)
			begin
				comparePc($sformatf("bundle_o.pred[%0d].target", s),
					expected.pred[s].target, actual.pred[s].target);	// Untaken targets are don't care.
			end
		end
	end
	endtask

	function automatic fetchPkg::brTypeE lookupTrainedType(input logic [31:0] addr);
		fetchPkg::brTypeE found;
	begin
		found = fetchPkg::brReturn;
		for (int i = 0; i < trainedPc.size(); i++)
		begin
			if (trainedPc[i] == addr)
			begin
				found = trainedType[i];	// Latest record for the address wins.
			end
		end
		return found;
	end
	endfunction

	task automatic clearInputs();
	begin
		stall    = 1'b0;
		redirect = '0;
		trainRec = '0;
		refill   = '0;
	end
	endtask

	task automatic waitForValid(input logic [31:0] lineAddr);
		int waited;
	begin
		waited = 0;
		while ((bundleValid !== 1'b1) && (waited < pollLimit))
		begin
			@(negedge clk);
			waited++;
		end
		if (bundleValid !== 1'b1)
		begin
			errorCount++;
			$display("Timeout, bundleValid_o stayed low %0d cycles after refill of line %h.",
				pollLimit, lineAddr);
		end
	end
	endtask

	task automatic checkOutputs();
	begin
		expBundle    = '0;
		expBundle.pc = expPc;
		for (int s = 0; s < fetchPkg::fetchSlots; s++)
		begin
			expBundle.inst[s]        = expWord + s;	// Golden lines count up from word 0.
			expBundle.pred[s].hit    = expHit[s];
			expBundle.pred[s].taken  = expTaken[s];
			expBundle.pred[s].target = expTarget;
			if (expHit[s])
			begin
				expBundle.pred[s].brType = lookupTrainedType(expPc + 4 * s);
			end
		end
		compareBundle(expBundle, bundle, expValid[0]);
		compareFlag("bundleValid_o", expValid[0], bundleValid);
		compareFlag("miss_o", !expValid[0], miss);
		comparePc("missAddr_o", {expPc[31:4], 4'h0}, missAddr);	// Line address of the PC.
	end
	endtask

	task automatic runOp();
	begin
		case (opWord)
			"refill":
			begin
				refill.en   = 1'b1;
				refill.addr = args[0];
				for (int w = 0; w < fetchPkg::lineInsts; w++)
				begin
					refill.line[w*fetchPkg::instWidth +: fetchPkg::instWidth] = args[1] + w;
				end
			end
			"train":
			begin
				trainRec.en     = 1'b1;
				trainRec.pc     = args[0];
				trainRec.target = args[1];
				trainRec.brType = fetchPkg::brTypeE'(args[2][1:0]);
				trainRec.taken  = args[3][0];
				if ((trainRec.brType != fetchPkg::brCond) || trainRec.taken)
				begin
					trainedPc.push_back(trainRec.pc);	// Not-taken conditionals stay out.
					trainedType.push_back(trainRec.brType);
				end
			end
			"redirectEx":
			begin
				redirect.exValid  = 1'b1;
				redirect.exTarget = args[0];
				redirect.idValid  = args[1][0];	// Optional competing decode redirect.
				redirect.idTarget = args[2];
				stall             = args[3][0];
			end
			"redirectId":
			begin
				redirect.idValid  = 1'b1;
				redirect.idTarget = args[0];
			end
			"stall":
			begin
				stall = 1'b1;
			end
			"step":
			begin
			end
			default:
			begin
				errorCount++;
				$display("Unknown opcode %0s in the golden file.", opWord);
			end
		endcase
		@(negedge clk);	// Exactly one rising edge.
		clearInputs();
		if ((opWord == "refill") && expValid[0])
		begin
			waitForValid(args[0]);
		end
		checkOutputs();
	end
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		opCount    = 0;
		reset      = 1'b1;
		clearInputs();
		repeat (4) @(posedge clk);	// Four reset cycles.
		@(negedge clk);
		reset = 1'b0;
		fd = $fopen("bench/fetchGolden.txt", "r");
		if (fd == 0)
		begin
			errorCount++;
			$display("Could not open bench/fetchGolden.txt for reading.");
		end
		else
		begin
			while ($fscanf(fd, "%s", opWord) == 1)
			begin
				if (opWord == "#")
				begin
					nRead = $fgets(restOfLine, fd);	// Legend line.
				end
				else
				begin
					nRead = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", args[0], args[1],
						args[2], args[3], expPc, expWord, expValid, expHit, expTaken, expTarget);
					if (nRead != 10)
					begin
						errorCount++;
						$display("Golden line for opcode %0s has missing columns.", opWord);
						break;
					end
					runOp();
					opCount++;
				end
			end
			$fclose(fd);
		end
		$display("Operations %0d, checks %0d, errors %0d", opCount, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== source/fetchTop.sv ====
`timescale 1ns/10ps

module fetchTop #(
	parameter logic [fetchPkg::pcWidth-1:0] resetPc = 32'h0000_1000,	// Boot address.
	parameter int btbEntries     = 16,	// BTB entries.
	parameter int counterEntries = 32,	// Direction counters.
	parameter int rasDepth       = 4,	// Return stack depth.
	parameter int cacheLines     = 16	// 16-byte lines, 256 bytes total.
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         stall_i,
	input  fetchPkg::redirectT           redirect_i,
	input  fetchPkg::trainT              train_i,
	input  fetchPkg::refillT             refill_i,
	output fetchPkg::fetchBundleT        bundle_o,
	output logic                         bundleValid_o,
	output logic                         miss_o,
	output logic [fetchPkg::pcWidth-1:0] missAddr_o
);

	fetchStage1 #(
		.resetPc(resetPc),
		.btbEntries(btbEntries),
		.counterEntries(counterEntries),
		.rasDepth(rasDepth),
		.cacheLines(cacheLines)
	) fs1 (
		.clk(clk),
		.reset(reset),
		.stall_i(stall_i),
		.redirect_i(redirect_i),
		.train_i(train_i),
		.refill_i(refill_i),
		.bundle_o(bundle_o),
		.bundleValid_o(bundleValid_o),
		.miss_o(miss_o),
		.missAddr_o(missAddr_o)
	);

endmodule

// ==== fetch/fetchStage1.sv ====
`timescale 1ns/10ps

module fetchStage1 #(
	parameter logic [fetchPkg::pcWidth-1:0] resetPc = '0,	// First fetch address.
	parameter int btbEntries     = 16,
	parameter int counterEntries = 32,
	parameter int rasDepth       = 4,
	parameter int cacheLines     = 16
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         stall_i,		// Back-pressure from decode.
	input  fetchPkg::redirectT           redirect_i,	// Recovery sources.
	input  fetchPkg::trainT              train_i,		// In-order branch training.
	input  fetchPkg::refillT             refill_i,		// Cache line from memory.
	output fetchPkg::fetchBundleT        bundle_o,		// Current PC, words and predictions.
	output logic                         bundleValid_o,	// Bundle present in the cache.
	output logic                         miss_o,
	output logic [fetchPkg::pcWidth-1:0] missAddr_o
);

	localparam int slotBits = $clog2(fetchPkg::fetchSlots);
	localparam logic [fetchPkg::pcWidth-1:0] bundleBytes =
		fetchPkg::fetchSlots * fetchPkg::instWidth / 8;	// PC step of 16 bytes.

	logic [fetchPkg::pcWidth-1:0]                       pc;			// Program counter.
	logic [fetchPkg::pcWidth-1:0]                       predPc;		// Predicted next PC.
	logic [fetchPkg::fetchSlots-1:0][fetchPkg::instWidth-1:0] cacheInst;
	logic                                               miss;
	logic [fetchPkg::fetchSlots-1:0]                    btbHit;
	fetchPkg::brTypeE [fetchPkg::fetchSlots-1:0]        btbType;
	logic [fetchPkg::fetchSlots-1:0][fetchPkg::pcWidth-1:0] btbTarget;
	logic [fetchPkg::fetchSlots-1:0]                    dirTaken;
	logic [fetchPkg::fetchSlots-1:0]                    slotTaken;	// Hit and predicted taken.
	logic [fetchPkg::fetchSlots-1:0][fetchPkg::pcWidth-1:0] slotTarget;
	logic [fetchPkg::fetchSlots-1:0][fetchPkg::pcWidth-1:0] retAddr;	// Slot PC plus 4.
	fetchPkg::slotPredT [fetchPkg::fetchSlots-1:0]      slotPred;
	logic                                               anyTaken;
	logic [slotBits-1:0]                                firstSlot;	// Lowest taken slot.
	logic [fetchPkg::pcWidth-1:0]                       rasTop;
	logic                                               rasPush;
	logic                                               rasPop;
	logic                                               advance;	// PC follows the prediction.
	logic                                               btbWrEn;
	logic                                               bpWrEn;

	// Not-taken conditionals stay out of the BTB. Only conditionals train counters.
	assign btbWrEn = train_i.en && !((train_i.brType == fetchPkg::brCond) && !train_i.taken);
	assign bpWrEn  = train_i.en && (train_i.brType == fetchPkg::brCond);

	branchTargetBuffer #(.btbEntries(btbEntries)) btb (
		.clk(clk), .reset(reset), .pc_i(pc), .train_i(train_i), .trainEn_i(btbWrEn),
		.hit_o(btbHit), .type_o(btbType), .target_o(btbTarget));

	directionPredictor #(.counterEntries(counterEntries)) bp (
		.clk(clk), .reset(reset), .pc_i(pc), .trainPc_i(train_i.pc),
		.trainTaken_i(train_i.taken), .trainEn_i(bpWrEn), .taken_o(dirTaken));

	returnAddrStack #(.rasDepth(rasDepth)) ras (
		.clk(clk), .reset(reset), .push_i(rasPush), .pushAddr_i(retAddr[firstSlot]),
		.pop_i(rasPop), .top_o(rasTop));

	instCache #(.cacheLines(cacheLines)) icache (
		.clk(clk), .reset(reset), .pc_i(pc), .refill_i(refill_i), .inst_o(cacheInst),
		.miss_o(miss), .missAddr_o(missAddr_o));

	for (genvar s = 0; s < fetchPkg::fetchSlots; s++)
	begin : gSlot
		localparam logic [fetchPkg::pcWidth-1:0] nextOffset = (s + 1) * (fetchPkg::instWidth / 8);

		assign slotTaken[s]  = btbHit[s] && ((btbType[s] != fetchPkg::brCond) || dirTaken[s]);
		assign slotTarget[s] = (btbType[s] == fetchPkg::brReturn) ? rasTop : btbTarget[s];
		assign retAddr[s]    = pc + nextOffset;
		assign slotPred[s]   = '{hit: btbHit[s], taken: slotTaken[s] && (firstSlot == s),
			brType: btbType[s], target: slotTarget[s]};	// Later slots are masked.
	end

	always_comb
	begin
		anyTaken  = 1'b0;
		firstSlot = '0;
		for (int i = fetchPkg::fetchSlots - 1; i >= 0; i--)	// Downward scan so the lowest wins.
		begin
			if (slotTaken[i])
			begin
				anyTaken  = 1'b1;
				firstSlot = slotBits'(i);
			end
		end
		predPc = anyTaken ? slotTarget[firstSlot] : pc + bundleBytes;
	end

	// RAS moves only on the edge where the PC takes the predicted path.
	assign advance = !redirect_i.exValid && !redirect_i.idValid && !stall_i && !miss;
	assign rasPush = advance && anyTaken && (btbType[firstSlot] == fetchPkg::brCall);
	assign rasPop  = advance && anyTaken && (btbType[firstSlot] == fetchPkg::brReturn);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= resetPc;
		end
		else if (redirect_i.exValid)
		begin
			pc <= redirect_i.exTarget;	// Wins even under stall.
		end
		else if (!stall_i && !miss)
		begin
			pc <= redirect_i.idValid ? redirect_i.idTarget : predPc;
		end
	end

	assign bundle_o      = '{pc: pc, inst: cacheInst, pred: slotPred};
	assign bundleValid_o = !miss;
	assign miss_o        = miss;

	assert property (@(posedge clk) disable iff (reset) !(rasPush && rasPop))
		else $error("RAS push and pop in the same cycle.");

endmodule

// ==== icache/instCache.sv ====
`timescale 1ns/10ps

module instCache #(
	parameter int cacheLines = 16	// Number of lines, a power of two.
) (
	input  logic                                                       clk,
	input  logic                                                       reset,
	input  logic [fetchPkg::pcWidth-1:0]                               pc_i,		// Fetch address.
	input  fetchPkg::refillT                                           refill_i,	// Line from memory.
	output logic [fetchPkg::lineInsts-1:0][fetchPkg::instWidth-1:0]    inst_o,		// Whole line.
	output logic                                                       miss_o,		// Line absent.
	output logic [fetchPkg::pcWidth-1:0]                               missAddr_o	// Line address.
);

	localparam int offBits = $clog2(fetchPkg::lineInsts * fetchPkg::instWidth / 8);	// 16 bytes.
	localparam int idxBits = $clog2(cacheLines);
	localparam int tagBits = fetchPkg::pcWidth - idxBits - offBits;

	logic [cacheLines-1:0] valid;			// Cleared on reset.
	logic [tagBits-1:0]    tags [cacheLines];	// Payload arrays carry no reset.
	logic [fetchPkg::lineInsts-1:0][fetchPkg::instWidth-1:0] lines [cacheLines];
	logic [idxBits-1:0]    rdIdx;
	logic [tagBits-1:0]    rdTag;
	logic [idxBits-1:0]    wrIdx;
	logic [tagBits-1:0]    wrTag;

	assign rdIdx = pc_i[offBits +: idxBits];
	assign rdTag = pc_i[fetchPkg::pcWidth-1 -: tagBits];
	assign wrIdx = refill_i.addr[offBits +: idxBits];
	assign wrTag = refill_i.addr[fetchPkg::pcWidth-1 -: tagBits];

	// Read is purely combinational from the arrays.
	assign inst_o     = lines[rdIdx];
	assign miss_o     = !(valid[rdIdx] && (tags[rdIdx] == rdTag));	// Hit needs valid and tag.
	assign missAddr_o = {pc_i[fetchPkg::pcWidth-1:offBits], {offBits{1'b0}}};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid <= '0;	// Cold cache.
		end
		else if (refill_i.en)
		begin
			valid[wrIdx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (refill_i.en)
		begin
			tags[wrIdx]  <= wrTag;
			lines[wrIdx] <= refill_i.line;	// Whole line at once.
		end
	end

	// Memory returns only whole lines at their natural alignment.
	assert property (@(posedge clk) disable iff (reset)
		refill_i.en |-> (refill_i.addr[offBits-1:0] == '0))
		else $error("Refill address %h is not line aligned.", refill_i.addr);

endmodule

// ==== source/returnAddrStack.sv ====
`timescale 1ns/10ps

module returnAddrStack #(
	parameter int rasDepth = 4	// Entries, a power of two so the pointer wraps.
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push_i,		// Call on the predicted path.
	input  logic [fetchPkg::pcWidth-1:0] pushAddr_i,	// Call slot address plus 4.
	input  logic                         pop_i,			// Return on the predicted path.
	output logic [fetchPkg::pcWidth-1:0] top_o			// Most recent return address.
);

	localparam int ptrBits = $clog2(rasDepth);

	logic [fetchPkg::pcWidth-1:0] stack [rasDepth];	// Return addresses, no reset.
	logic [ptrBits-1:0]           ptr;				// Next free entry.
	logic [ptrBits-1:0]           topPtr;

	// Top sits one below the free pointer, wrapping when empty.
	assign topPtr = ptr - 1'b1;
	assign top_o  = stack[topPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;	// Empty stack.
		end
		else if (push_i)
		begin
			ptr <= ptr + 1'b1;	// Full stack wraps onto the oldest entry.
		end
		else if (pop_i)
		begin
			ptr <= topPtr;	// Underflow simply wraps.
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_i)
		begin
			stack[ptr] <= pushAddr_i;	// Overwrites the oldest entry on overflow.
		end
	end

endmodule

// ==== source/directionPredictor.sv ====
`timescale 1ns/10ps

module directionPredictor #(
	parameter int counterEntries = 32	// Counter table size, a power of two.
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [fetchPkg::pcWidth-1:0]    pc_i,			// Bundle PC.
	input  logic [fetchPkg::pcWidth-1:0]    trainPc_i,		// Resolved branch address.
	input  logic                            trainTaken_i,	// Resolved direction.
	input  logic                            trainEn_i,		// Conditional records only.
	output logic [fetchPkg::fetchSlots-1:0] taken_o			// Counter MSB per slot.
);

	localparam int idxBits = $clog2(counterEntries);

	logic [1:0]         counters [counterEntries];	// Two-bit saturating counters.
	logic [idxBits-1:0] wrIdx;

	assign wrIdx = trainPc_i[2 +: idxBits];

	for (genvar s = 0; s < fetchPkg::fetchSlots; s++)
	begin : gRead
		localparam logic [fetchPkg::pcWidth-1:0] slotOffset = 4 * s;
		logic [fetchPkg::pcWidth-1:0] slotPc;

		assign slotPc     = pc_i + slotOffset;
		assign taken_o[s] = counters[slotPc[2 +: idxBits]][1];	// 2 and 3 predict taken.
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < counterEntries; i++)
			begin
				counters[i] <= 2'b01;	// Weakly not taken.
			end
		end
		else if (trainEn_i)
		begin
			if (trainTaken_i && (counters[wrIdx] != 2'b11))
			begin
				counters[wrIdx] <= counters[wrIdx] + 2'b01;	// Count up, saturate at 3.
			end
			else if (!trainTaken_i && (counters[wrIdx] != 2'b00))
			begin
				counters[wrIdx] <= counters[wrIdx] - 2'b01;	// count down, saturate at 0
			end
		end
	end

endmodule

// ==== source/branchTargetBuffer.sv ====
`timescale 1ns/10ps

module branchTargetBuffer #(
	parameter int btbEntries = 16	// Table size, a power of two.
) (
	input  logic                                                clk,
	input  logic                                                reset,
	input  logic [fetchPkg::pcWidth-1:0]                        pc_i,		// Bundle PC.
	input  fetchPkg::trainT                                     train_i,	// Training record.
	input  logic                                                trainEn_i,	// Write strobe.
	output logic [fetchPkg::fetchSlots-1:0]                     hit_o,		// Per-slot hit.
	output fetchPkg::brTypeE [fetchPkg::fetchSlots-1:0]         type_o,		// Per-slot class.
	output logic [fetchPkg::fetchSlots-1:0][fetchPkg::pcWidth-1:0] target_o	// Per-slot target.
);

	localparam int idxBits = $clog2(btbEntries);			// Word address bits used as index.
	localparam int tagBits = fetchPkg::pcWidth - idxBits - 2;	// Remaining upper bits.

	typedef struct packed {
		logic [tagBits-1:0]            tag;
		fetchPkg::brTypeE              brType;
		logic [fetchPkg::pcWidth-1:0]  target;
	} btbEntryT;

	btbEntryT              entries [btbEntries];	// Payload, no reset.
	logic [btbEntries-1:0] valid;					// Cleared on reset.
	logic [idxBits-1:0]    wrIdx;
	logic [tagBits-1:0]    wrTag;

	assign wrIdx = train_i.pc[2 +: idxBits];				// Index by word address.
	assign wrTag = train_i.pc[fetchPkg::pcWidth-1 -: tagBits];

	// Four read ports, one per consecutive instruction of the bundle.
	for (genvar s = 0; s < fetchPkg::fetchSlots; s++)
	begin : gRead
		localparam logic [fetchPkg::pcWidth-1:0] slotOffset = 4 * s;	// Byte offset of slot.
		logic [fetchPkg::pcWidth-1:0] slotPc;
		logic [idxBits-1:0]           idx;

		assign slotPc      = pc_i + slotOffset;
		assign idx         = slotPc[2 +: idxBits];
		assign hit_o[s]    = valid[idx] && (entries[idx].tag == slotPc[fetchPkg::pcWidth-1 -: tagBits]);
		assign type_o[s]   = entries[idx].brType;
		assign target_o[s] = entries[idx].target;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid <= '0;	// Empty table.
		end
		else if (trainEn_i)
		begin
			valid[wrIdx] <= 1'b1;	// Entry becomes visible next cycle.
		end
	end

	always_ff @(posedge clk)
	begin
		if (trainEn_i)
		begin
			entries[wrIdx] <= '{tag: wrTag, brType: train_i.brType, target: train_i.target};
		end
	end

	// Training comes from the back end, which only ever resolves whole words.
	assert property (@(posedge clk) disable iff (reset) trainEn_i |-> (train_i.pc[1:0] == 2'b00))
		else $error("BTB training PC %h is not word aligned.", train_i.pc);

endmodule

// ==== common/fetchPkg.sv ====
package fetchPkg;

	parameter int pcWidth    = 32;	// Fetch address width.
	parameter int instWidth  = 32;	// One instruction word.
	parameter int fetchSlots = 4;	// Instructions per fetch bundle.
	parameter int lineInsts  = 4;	// Instructions per cache line, one line is one bundle.

	// Control instruction class as stored in the BTB and carried by training.
	typedef enum logic [1:0] {
		brReturn = 2'b00,	// Target comes from the RAS.
		brCall   = 2'b01,	// Pushes the return address.
		brJump   = 2'b10,	// Always taken, direct or indirect.
		brCond   = 2'b11	// Direction from the counter table.
	} brTypeE;

	typedef struct packed {
		logic                 hit;		// BTB hit for this slot.
		logic                 taken;	// Slot is the first predicted taken slot.
		brTypeE               brType;	// Stored branch class.
		logic [pcWidth-1:0]   target;	// Predicted target, RAS top for a return.
	} slotPredT;

	typedef struct packed {
		logic [pcWidth-1:0]                     pc;		// Address of slot 0.
		logic [fetchSlots-1:0][instWidth-1:0]   inst;	// Slot 0 in the low word.
		slotPredT [fetchSlots-1:0]              pred;	// Per-slot prediction.
	} fetchBundleT;

	typedef struct packed {
		logic                 en;		// Record is valid this cycle.
		logic [pcWidth-1:0]   pc;		// Address of the resolved branch.
		logic [pcWidth-1:0]   target;	// Resolved target.
		brTypeE               brType;	// Resolved class.
		logic                 taken;	// Resolved direction.
	} trainT;

	typedef struct packed {
		logic                           en;		// One-cycle write strobe.
		logic [pcWidth-1:0]             addr;	// Line aligned address.
		logic [lineInsts*instWidth-1:0] line;	// Word 0 in the low bits.
	} refillT;

	typedef struct packed {
		logic                 exValid;	// Execute-stage recovery, highest priority.
		logic [pcWidth-1:0]   exTarget;
		logic                 idValid;	// Decode-stage recovery.
		logic [pcWidth-1:0]   idTarget;
	} redirectT;

endpackage
